//--- design/rv_core_pkg.sv
// Shared definitions for the RV32I single-cycle core
// Widths, reset PC and PC step, vector types
// Major opcodes, funct3 codes and control selector enums
`default_nettype none

package rv_core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam logic [XLEN-1:0] PC_RESET    = '0;
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // Arithmetic and logic funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch condition funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_B, IMM_U, IMM_J} imm_src_e;

    typedef enum logic {ALU_SRC_REG, ALU_SRC_IMM} alu_src_e;

    typedef enum logic [1:0] {WB_ALU, WB_TARGET, WB_PC_PLUS4} wb_src_e;

    // Base of the second adder
    typedef enum logic [1:0] {TGT_PC, TGT_ZERO, TGT_RS1} target_src_e;

    typedef enum logic {PC_SRC_PLUS4, PC_SRC_TARGET} pc_src_e;

endpackage

`default_nettype wire

//--- design/pc_unit.sv
// Program counter register
// Second adder for branch, jump and upper-immediate targets
// Next-PC selection
`default_nettype none
`timescale 1ns/10ps

module pc_unit import rv_core_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  word_t       i_imm,
    input  word_t       i_rs1_data,
    input  target_src_e i_target_src,
    input  logic        i_jump,
    input  logic        i_branch_taken,
    output word_t       o_pc,
    output word_t       o_pc_plus4,
    output word_t       o_target
);

    word_t   pc_q;
    word_t   pc_next;
    word_t   rs1_sum;
    pc_src_e pc_src;

    assign o_pc       = pc_q;
    assign o_pc_plus4 = pc_q + INSTR_BYTES;
    assign rs1_sum    = i_rs1_data + i_imm;

    // Second adder
    always_comb begin
        case (i_target_src)
            TGT_PC:   o_target = pc_q + i_imm;
            TGT_ZERO: o_target = i_imm;
            // JALR clears bit 0 of the target
            TGT_RS1:  o_target = {rs1_sum[XLEN-1:1], 1'b0};
            default:  o_target = pc_q + i_imm;
        endcase
    end

    assign pc_src = (i_jump || i_branch_taken) ? PC_SRC_TARGET : PC_SRC_PLUS4;

    always_comb begin
        case (pc_src)
            PC_SRC_TARGET: pc_next = o_target;
            default:       pc_next = o_pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= PC_RESET;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
// Instruction decoder
// Opcode and function fields into control selects
// Immediate sign extension by format
`default_nettype none
`timescale 1ns/10ps

module instr_decoder import rv_core_pkg::*; (
    input  instr_t      i_instr,
    output reg_addr_t   o_rs1,
    output reg_addr_t   o_rs2,
    output reg_addr_t   o_rd,
    output word_t       o_imm,
    output alu_op_e     o_alu_op,
    output alu_src_e    o_alu_src,
    output wb_src_e     o_wb_src,
    output target_src_e o_target_src,
    output logic        o_reg_write,
    output logic        o_branch,
    output logic        o_jump,
    output logic [2:0]  o_funct3
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       bit30;
    imm_src_e   imm_src;
    alu_op_e    arith_op;

    assign opcode   = opcode_e'(i_instr[6:0]);
    assign funct3   = i_instr[14:12];
    assign bit30    = i_instr[30];
    assign o_funct3 = funct3;
    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_rd     = i_instr[11:7];

    // Shared ALU decode for OP and OP_IMM
    always_comb begin
        case (funct3)
            F3_ADD_SUB: arith_op = (opcode == OPC_OP && bit30) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: arith_op = bit30 ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        // Unknown opcodes retire as no-ops
        o_alu_op     = ALU_ADD;
        o_alu_src    = ALU_SRC_REG;
        o_wb_src     = WB_ALU;
        o_target_src = TGT_PC;
        o_reg_write  = 1'b0;
        o_branch     = 1'b0;
        o_jump       = 1'b0;
        imm_src      = IMM_I;
        case (opcode)
            OPC_OP: begin
                o_alu_op    = arith_op;
                o_reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                o_alu_op    = arith_op;
                o_alu_src   = ALU_SRC_IMM;
                o_reg_write = 1'b1;
            end
            OPC_LUI: begin
                imm_src      = IMM_U;
                o_target_src = TGT_ZERO;
                o_wb_src     = WB_TARGET;
                o_reg_write  = 1'b1;
            end
            OPC_AUIPC: begin
                imm_src     = IMM_U;
                o_wb_src    = WB_TARGET;
                o_reg_write = 1'b1;
            end
            OPC_JAL: begin
                imm_src     = IMM_J;
                o_wb_src    = WB_PC_PLUS4;
                o_reg_write = 1'b1;
                o_jump      = 1'b1;
            end
            OPC_JALR: begin
                o_target_src = TGT_RS1;
                o_wb_src     = WB_PC_PLUS4;
                o_reg_write  = 1'b1;
                o_jump       = 1'b1;
            end
            OPC_BRANCH: begin
                imm_src  = IMM_B;
                o_branch = 1'b1;
                // Equality via sub, ordering via the compare ops
                if (funct3 == F3_BLTU || funct3 == F3_BGEU) begin
                    o_alu_op = ALU_SLTU;
                end else if (funct3 == F3_BLT || funct3 == F3_BGE) begin
                    o_alu_op = ALU_SLT;
                end else begin
                    o_alu_op = ALU_SUB;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_src)
            IMM_B:   o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                              i_instr[30:25], i_instr[11:8], 1'b0};
            IMM_U:   o_imm = {i_instr[31:12], 12'b0};
            IMM_J:   o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                              i_instr[20], i_instr[30:21], 1'b0};
            default: o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
// Integer register file
// Two combinational read ports, one write port, x0 reads zero
`default_nettype none
`timescale 1ns/10ps

module reg_file import rv_core_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  logic      i_we,
    input  reg_addr_t i_rd,
    input  word_t     i_wd,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wd;
        end
    end

    // x0 is hardwired to zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

//--- design/execute_unit.sv
// Execute stage
// ALU operand select and ALU
// Branch condition and write-back source select
`default_nettype none
`timescale 1ns/10ps

module execute_unit import rv_core_pkg::*; (
    input  word_t      i_rs1_data,
    input  word_t      i_rs2_data,
    input  word_t      i_imm,
    input  word_t      i_pc_plus4,
    input  word_t      i_target,
    input  alu_op_e    i_alu_op,
    input  alu_src_e   i_alu_src,
    input  wb_src_e    i_wb_src,
    input  logic       i_reg_write,
    input  logic       i_branch,
    input  logic [2:0] i_funct3,
    input  reg_addr_t  i_rd,
    output logic       o_branch_taken,
    output logic       o_wb_valid,
    output reg_addr_t  o_wb_rd,
    output word_t      o_wb_data
);

    word_t      alu_b;
    word_t      alu_result;
    logic [4:0] shamt;
    logic       alu_zero;
    logic       cond;

    assign alu_b = (i_alu_src == ALU_SRC_IMM) ? i_imm : i_rs2_data;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (i_alu_op)
            ALU_SUB:  alu_result = i_rs1_data - alu_b;
            ALU_AND:  alu_result = i_rs1_data & alu_b;
            ALU_OR:   alu_result = i_rs1_data | alu_b;
            ALU_XOR:  alu_result = i_rs1_data ^ alu_b;
            ALU_SLL:  alu_result = i_rs1_data << shamt;
            ALU_SRL:  alu_result = i_rs1_data >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(i_rs1_data) >>> shamt);
            ALU_SLT:  alu_result = {31'b0, $signed(i_rs1_data) < $signed(alu_b)};
            ALU_SLTU: alu_result = {31'b0, i_rs1_data < alu_b};
            default:  alu_result = i_rs1_data + alu_b;
        endcase
    end

    assign alu_zero = (alu_result == '0);

    // Compare bit is bit 0 of the slt/sltu result
    always_comb begin
        case (i_funct3)
            F3_BEQ:  cond = alu_zero;
            F3_BNE:  cond = !alu_zero;
            F3_BLT:  cond = alu_result[0];
            F3_BGE:  cond = !alu_result[0];
            F3_BLTU: cond = alu_result[0];
            F3_BGEU: cond = !alu_result[0];
            default: cond = 1'b0;
        endcase
    end

    assign o_branch_taken = i_branch && cond;

    always_comb begin
        case (i_wb_src)
            WB_TARGET:   o_wb_data = i_target;
            WB_PC_PLUS4: o_wb_data = i_pc_plus4;
            default:     o_wb_data = alu_result;
        endcase
    end

    // Writes to x0 are dropped here
    assign o_wb_valid = i_reg_write && (i_rd != '0);
    assign o_wb_rd    = i_rd;

endmodule

`default_nettype wire

//--- design/rv_core.sv
// Single-cycle RV32I core top level
// PC unit, decoder, register file and execute unit
`default_nettype none
`timescale 1ns/10ps

module rv_core import rv_core_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  instr_t    i_instr,
    output word_t     o_pc,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_rd,
    output word_t     o_wb_data
);

    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       imm;
    alu_op_e     alu_op;
    alu_src_e    alu_src;
    wb_src_e     wb_src;
    target_src_e target_src;
    logic        reg_write;
    logic        branch;
    logic        jump;
    logic [2:0]  funct3;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       pc_plus4;
    word_t       target;
    logic        branch_taken;
    logic        wb_valid;

    pc_unit pc_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_imm          (imm),
        .i_rs1_data     (rs1_data),
        .i_target_src   (target_src),
        .i_jump         (jump),
        .i_branch_taken (branch_taken),
        .o_pc           (o_pc),
        .o_pc_plus4     (pc_plus4),
        .o_target       (target)
    );

    instr_decoder decoder_i (
        .i_instr      (i_instr),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_rd         (rd),
        .o_imm        (imm),
        .o_alu_op     (alu_op),
        .o_alu_src    (alu_src),
        .o_wb_src     (wb_src),
        .o_target_src (target_src),
        .o_reg_write  (reg_write),
        .o_branch     (branch),
        .o_jump       (jump),
        .o_funct3     (funct3)
    );

    // Write port fed by the same strobe seen at the top
    reg_file reg_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_we       (o_wb_valid),
        .i_rd       (o_wb_rd),
        .i_wd       (o_wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    execute_unit execute_i (
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_imm          (imm),
        .i_pc_plus4     (pc_plus4),
        .i_target       (target),
        .i_alu_op       (alu_op),
        .i_alu_src      (alu_src),
        .i_wb_src       (wb_src),
        .i_reg_write    (reg_write),
        .i_branch       (branch),
        .i_funct3       (funct3),
        .i_rd           (rd),
        .o_branch_taken (branch_taken),
        .o_wb_valid     (wb_valid),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data)
    );

    // No write-back is reported while reset is held
    assign o_wb_valid = wb_valid && rst_n;

endmodule

`default_nettype wire

//--- testbench/rv_core_props.sv
// Concurrent protocol checks on the core top level
// Bound to rv_core
`default_nettype none
`timescale 1ns/10ps

module rv_core_props import rv_core_pkg::*; (
    input wire       clk,
    input wire       rst_n,
    input word_t     i_pc,
    input logic      i_wb_valid,
    input reg_addr_t i_wb_rd,
    input logic      i_jump,
    input logic      i_branch_taken
);

    // The PC is unknown before the first edge
    logic started = 1'b0;

    always @(posedge clk) begin
        started <= 1'b1;
    end

    pc_aligned: assert property (@(posedge clk) started |-> i_pc[1:0] == 2'b00)
        else $error("PC is not word-aligned");

    wb_not_x0: assert property (@(posedge clk) started && i_wb_valid |-> i_wb_rd != '0)
        else $error("Write-back strobe raised for register zero");

    reset_state: assert property (@(posedge clk)
        started && !rst_n |-> i_pc == PC_RESET && !i_wb_valid)
        else $error("PC or write-back strobe wrong during reset");

    // Sequential flow when nothing redirects the PC
    pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        started && !i_jump && !i_branch_taken |=> i_pc == $past(i_pc) + INSTR_BYTES)
        else $error("PC did not advance by four");

endmodule

bind rv_core rv_core_props props_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_pc           (o_pc),
    .i_wb_valid     (o_wb_valid),
    .i_wb_rd        (o_wb_rd),
    .i_jump         (jump),
    .i_branch_taken (branch_taken)
);

`default_nettype wire

//--- testbench/tb_rv_core.sv
// Testbench for the single-cycle RV32I core
// Clock, reset and instruction ROM holding a hand-assembled program
// Instruction-level reference model compared with the DUT every cycle
`default_nettype none
`timescale 1ns/10ps

module tb_rv_core import rv_core_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DLY    = 1;
    localparam int ROM_WORDS    = 128;
    // Slack on top of the program length, covers the countdown loop
    localparam int CYCLE_MARGIN = 20;

    logic      clk = 1'b0;
    logic      rst_n;
    instr_t    instr;
    word_t     pc;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    instr_t rom [ROM_WORDS];
    int     prog_len;
    word_t  end_pc;

    // Reference model state
    word_t  model_pc;
    word_t  model_regs [NUM_REGS];

    int     seed = 32'hfb0a_0f16;
    int     value_errors;
    int     timeouts;
    int     cycles;
    int     cycle_limit;
    logic   end_reached;

    rv_core dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_instr    (instr),
        .o_pc       (pc),
        .o_wb_valid (wb_valid),
        .o_wb_rd    (wb_rd),
        .o_wb_data  (wb_data)
    );

    // The ROM answers the fetch address in the same cycle
    assign instr = rom[pc[8:2]];

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
    endfunction

    function automatic instr_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                      input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic instr_t u_type(input logic [6:0] opc, input int rd,
                                      input logic [19:0] imm);
        return {imm, 5'(rd), opc};
    endfunction

    function automatic instr_t b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                      input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'h63};
    endfunction

    function automatic instr_t j_type(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic emit(input instr_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    // Upper part rounded up so the signed low 12 bits add back correctly
    task automatic load_constant(input int rd, input word_t value);
        word_t upper;
        upper = value + 32'h0000_0800;
        emit(u_type(7'h37, rd, upper[31:12]));
        emit(i_type(7'h13, 3'b000, rd, rd, int'(value[11:0])));
    endtask

    // Taken branch skips a slot, the not-taken one falls into it
    task automatic branch_pair(input logic [2:0] f3, input int take_a, input int take_b,
                               input int fall_a, input int fall_b);
        emit(b_type(f3, take_a, take_b, 8));
        emit(i_type(7'h13, 3'b000, 31, 31, 1));
        emit(b_type(f3, fall_a, fall_b, 8));
        emit(i_type(7'h13, 3'b000, 31, 31, 1));
    endtask

    task automatic build_program();
        word_t ra;
        word_t rb;
        ra = word_t'($random(seed)) | 32'h8000_0000;
        rb = word_t'($random(seed)) & 32'h7fff_ffff;
        prog_len = 0;
        // Address 0 holds a LUI that writes x1, seen on the bus during reset
        load_constant(1, ra);
        load_constant(2, rb);
        // x1 negative, x2 positive
        emit(r_type(7'h00, 3'b000, 3, 1, 2));
        emit(r_type(7'h20, 3'b000, 4, 1, 2));
        emit(r_type(7'h00, 3'b111, 5, 1, 2));
        emit(r_type(7'h00, 3'b110, 6, 1, 2));
        emit(r_type(7'h00, 3'b100, 7, 1, 2));
        emit(r_type(7'h00, 3'b001, 8, 1, 2));
        emit(r_type(7'h00, 3'b101, 9, 1, 2));
        emit(r_type(7'h20, 3'b101, 10, 1, 2));
        emit(r_type(7'h00, 3'b010, 11, 1, 2));
        emit(r_type(7'h00, 3'b011, 12, 1, 2));
        emit(r_type(7'h00, 3'b010, 13, 2, 1));
        emit(r_type(7'h00, 3'b011, 14, 2, 1));
        emit(i_type(7'h13, 3'b000, 15, 1, -5));
        emit(i_type(7'h13, 3'b010, 16, 1, -1));
        emit(i_type(7'h13, 3'b011, 17, 1, -1));
        emit(i_type(7'h13, 3'b100, 18, 1, 'h555));
        emit(i_type(7'h13, 3'b110, 19, 2, 'h0f0));
        emit(i_type(7'h13, 3'b111, 20, 1, 'h7ff));
        emit(i_type(7'h13, 3'b001, 21, 1, 7));
        emit(i_type(7'h13, 3'b101, 22, 1, 9));
        emit(i_type(7'h13, 3'b101, 23, 1, 'h409));
        emit(u_type(7'h37, 24, 20'habcde));
        emit(u_type(7'h17, 25, 20'h12345));
        // x26 is a copy of x1 for the equal cases
        emit(i_type(7'h13, 3'b000, 26, 1, 0));
        branch_pair(3'b000, 1, 26, 1, 2);
        branch_pair(3'b001, 1, 2, 1, 26);
        branch_pair(3'b100, 1, 2, 2, 1);
        branch_pair(3'b101, 2, 1, 1, 2);
        branch_pair(3'b110, 2, 1, 1, 2);
        branch_pair(3'b111, 1, 2, 2, 1);
        // Countdown loop with a backward branch
        emit(i_type(7'h13, 3'b000, 27, 0, 3));
        emit(i_type(7'h13, 3'b000, 27, 27, -1));
        emit(b_type(3'b001, 27, 0, -4));
        // JAL over two slots that never run
        emit(j_type(28, 12));
        emit(i_type(7'h13, 3'b000, 31, 31, 100));
        emit(i_type(7'h13, 3'b000, 31, 31, 100));
        // JALR to an odd sum, lands on the word after the slot
        emit(u_type(7'h17, 29, 20'h00000));
        emit(i_type(7'h67, 3'b000, 30, 29, 13));
        emit(i_type(7'h13, 3'b000, 31, 31, 100));
        emit(i_type(7'h13, 3'b000, 0, 1, 123));
        emit(r_type(7'h00, 3'b000, 0, 1, 2));
        emit(r_type(7'h00, 3'b000, 31, 0, 2));
        // Load word is not supported and retires as a no-op
        emit(i_type(7'h03, 3'b010, 5, 1, 0));
        end_pc = word_t'(prog_len) << 2;
        emit(j_type(0, 0));
    endtask

    function automatic word_t expected_alu(input logic [2:0] f3, input logic alt,
                                           input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_holds(input logic [2:0] f3, input word_t a,
                                          input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Executes one instruction at model_pc and returns the expected write-back
    task automatic step_model(output logic exp_valid, output reg_addr_t exp_rd,
                              output word_t exp_data);
        instr_t     ins;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      next_pc;
        logic       writes;
        ins      = rom[model_pc[8:2]];
        f3       = ins[14:12];
        a        = model_regs[ins[19:15]];
        b        = model_regs[ins[24:20]];
        imm_i    = {{20{ins[31]}}, ins[31:20]};
        next_pc  = model_pc + 32'd4;
        writes   = 1'b1;
        exp_data = '0;
        case (ins[6:0])
            7'h33: exp_data = expected_alu(f3, ins[30], a, b);
            7'h13: exp_data = expected_alu(f3, ins[30] && f3 == 3'b101, a, imm_i);
            7'h37: exp_data = {ins[31:12], 12'h000};
            7'h17: exp_data = model_pc + {ins[31:12], 12'h000};
            7'h6f: begin
                exp_data = next_pc;
                next_pc  = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                exp_data = next_pc;
                next_pc  = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                writes = 1'b0;
                if (branch_holds(f3, a, b)) begin
                    next_pc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: writes = 1'b0;
        endcase
        exp_rd    = ins[11:7];
        exp_valid = writes && (exp_rd != 5'd0);
        if (exp_valid) begin
            model_regs[exp_rd] = exp_data;
        end
        model_pc = next_pc;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin : cycle_check
        logic      exp_valid;
        reg_addr_t exp_rd;
        word_t     exp_data;
        if (!rst_n) begin
            model_pc = PC_RESET;
            for (int i = 0; i < NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
            check_value("o_pc", pc, PC_RESET);
            check_value("o_wb_valid", 32'(wb_valid), 32'd0);
        end else if (!end_reached) begin
            check_value("o_pc", pc, model_pc);
            end_reached = (pc == end_pc);
            step_model(exp_valid, exp_rd, exp_data);
            check_value("o_wb_valid", 32'(wb_valid), 32'(exp_valid));
            if (exp_valid) begin
                check_value("o_wb_rd", 32'(wb_rd), 32'(exp_rd));
                check_value("o_wb_data", wb_data, exp_data);
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        value_errors = 0;
        timeouts     = 0;
        cycles       = 0;
        end_reached  = 1'b0;
        // Unused words hold an unknown opcode tagged with their index
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = {i[24:0], 7'h0b};
        end
        build_program();
        cycle_limit = prog_len + CYCLE_MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        while (!end_reached && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!end_reached) begin
            timeouts++;
            $display("Timeout: the core did not reach the end of the program in %0d cycles",
                     cycle_limit);
        end
        $display("Closing: %0d value errors, %0d timeouts, %0d cycles run",
                 value_errors, timeouts, cycles);
        if (value_errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/rv_core_pkg.sv
design/pc_unit.sv
design/instr_decoder.sv
design/reg_file.sv
design/execute_unit.sv
design/rv_core.sv
testbench/rv_core_props.sv
testbench/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
# The result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f files.f -o tb_rv_core_sim \
    && ./obj_dir/tb_rv_core_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "All checks passed" "$LOG" && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
